/* int_exec.f */
int_exec_pkg.sv
dispatch_steer.sv
issue_queue.sv
operand_stage.sv
alu.sv
int_exec_block.sv
tb_int_exec_assertions.sv
tb_int_exec.sv

/* int_exec_cases.txt */
# pre tag(dec) value(hex) | ins op src0 src1 use_imm imm(hex) dst | ext tag value cycle
# ops 0 add 1 sub 2 and 3 or 4 xor 5 sll 6 srl 7 slt 8 sltu
case independent
pre 1 80000005
pre 2 00000003
ins 0 1 2 0 000 10
ins 1 1 2 0 000 11
ins 2 1 2 0 000 12
ins 3 1 2 0 000 13
ins 4 1 2 0 000 14
ins 5 1 2 0 000 15
ins 6 1 2 0 000 16
ins 7 1 2 0 000 17
ins 8 1 2 0 000 18
end
case chain
pre 3 00000010
pre 4 00000007
ins 0 3 4 0 000 20
ins 1 20 4 0 000 21
ins 5 21 4 0 000 22
ins 4 22 20 0 000 23
ins 6 23 4 0 000 24
end
case immediate
pre 5 00000100
ins 0 5 0 1 fff 30
ins 0 30 0 1 800 31
ins 7 31 0 1 000 32
ins 3 32 0 1 7f0 33
ins 8 5 0 1 fff 34
end
case external
ext 40 0000abcd 6
ins 0 40 40 0 000 41
ins 2 41 40 0 000 42
end
case burst
ext 43 00000001 40
ins 0 43 0 1 001 44
ins 0 44 0 1 001 45
ins 0 45 0 1 001 46
ins 0 46 0 1 001 47
ins 0 47 0 1 001 48
ins 0 48 0 1 001 49
ins 0 49 0 1 001 50
ins 0 50 0 1 001 51
ins 0 51 0 1 001 52
ins 0 52 0 1 001 53
ins 0 53 0 1 001 54
ins 0 54 0 1 001 55
ins 0 55 0 1 001 56
ins 0 56 0 1 001 57
ins 0 57 0 1 001 58
ins 0 58 0 1 001 59
ins 0 59 0 1 001 60
ins 0 60 0 1 001 61
end

/* tb_int_exec.sv */
`timescale 1ns/10ps

module tb_int_exec;
    import int_exec_pkg::*;

    localparam int MAX_INS = 32;
    localparam int MAX_EXT = 4;

    logic                  clk;
    logic                  rst;
    logic [DISP_WIDTH-1:0] disp_vld;
    alu_op_e               disp_op [DISP_WIDTH];
    preg_t                 disp_src0 [DISP_WIDTH];
    preg_t                 disp_src1 [DISP_WIDTH];
    logic [1:0]            disp_src_rdy [DISP_WIDTH];
    logic [DISP_WIDTH-1:0] disp_use_imm;
    imm_t                  disp_imm [DISP_WIDTH];
    preg_t                 disp_dst [DISP_WIDTH];
    logic [DISP_WIDTH-1:0] disp_accept;
    preg_t                 rf_idx [LANE_NUM][2];
    word_t                 rf_data [LANE_NUM][2];
    logic [LANE_NUM-1:0]   wb_vld;
    preg_t                 wb_tag [LANE_NUM];
    word_t                 wb_data [LANE_NUM];
    logic                  ext_vld;
    preg_t                 ext_tag;
    word_t                 ext_data;

    // register file model
    word_t rf_val [PREG_NUM];
    logic  rf_wr [PREG_NUM];

    // current case
    string case_name;
    int    n_ins;
    int    n_ext;
    int    ins_op [MAX_INS];
    preg_t ins_src0 [MAX_INS];
    preg_t ins_src1 [MAX_INS];
    logic  ins_use_imm [MAX_INS];
    imm_t  ins_imm [MAX_INS];
    preg_t ins_dst [MAX_INS];
    word_t ins_exp [MAX_INS];
    logic  ins_done [MAX_INS];
    preg_t ext_tags [MAX_EXT];
    word_t ext_vals [MAX_EXT];
    int    ext_cyc [MAX_EXT];
    int    pending;

    int_exec_block dut0 (
        .clk (clk), .rst (rst),
        .i_disp_vld (disp_vld), .i_disp_op (disp_op),
        .i_disp_src0 (disp_src0), .i_disp_src1 (disp_src1),
        .i_disp_src_rdy (disp_src_rdy), .i_disp_use_imm (disp_use_imm),
        .i_disp_imm (disp_imm), .i_disp_dst (disp_dst),
        .o_disp_accept (disp_accept),
        .o_rf_idx (rf_idx), .i_rf_data (rf_data),
        .o_wb_vld (wb_vld), .o_wb_tag (wb_tag), .o_wb_data (wb_data),
        .i_ext_wb_vld (ext_vld), .i_ext_wb_tag (ext_tag), .i_ext_wb_data (ext_data)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (exp !== act) begin
            $display("Mismatch %s: expected %h actual %h", name, exp, act);
            fail_run("wrong writeback data");
        end
    endtask

    task automatic check_tag(input string name, input preg_t exp, input preg_t act);
        if (exp !== act) begin
            $display("Mismatch %s: expected tag %0d actual tag %0d", name, exp, act);
            fail_run("wrong writeback tag");
        end
    endtask

    // reference ALU built from the operation table
    function automatic word_t alu_ref(int op, word_t a, word_t b);
        case (op)
            0: return a + b;
            1: return a - b;
            2: return a & b;
            3: return a | b;
            4: return a ^ b;
            5: return a << b[4:0];
            6: return a >> b[4:0];
            7: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: return (a < b) ? 32'd1 : 32'd0;
        endcase
    endfunction

    // writes happen before the register read of the same edge
    always @(posedge clk) begin
        int hit;
        int first;
        for (int l = 0; l < LANE_NUM; l++) begin
            if (!rst && wb_vld[l]) begin
                hit = -1;
                first = -1;
                for (int i = 0; i < n_ins; i++) begin
                    if (!ins_done[i] && first < 0) first = i;
                    if (!ins_done[i] && ins_dst[i] == wb_tag[l]) hit = i;
                end
                if (first < 0) begin
                    fail_run("writeback seen with no instruction outstanding");
                end
                if (hit < 0) begin
                    check_tag(case_name, ins_dst[first], wb_tag[l]);
                end
                check_word(case_name, ins_exp[hit], wb_data[l]);
                ins_done[hit] = 1'b1;
                pending--;
                rf_val[wb_tag[l]] = wb_data[l];
                rf_wr[wb_tag[l]] = 1'b1;
            end
        end
        if (ext_vld) begin
            rf_val[ext_tag] = ext_data;
            rf_wr[ext_tag] = 1'b1;
        end
        for (int l = 0; l < LANE_NUM; l++) begin
            rf_data[l][0] <= rf_val[rf_idx[l][0]];
            rf_data[l][1] <= rf_val[rf_idx[l][1]];
        end
    end

    // a failed protocol assertion ends the run at once
    always @(posedge clk) begin
        if (dut0.u_chk.fail_cnt != 0) begin
            fail_run("a protocol assertion failed");
        end
    end

    task automatic drive_slot(input int s, input int i);
        disp_vld[s]        = 1'b1;
        disp_op[s]         = alu_op_e'(ins_op[i]);
        disp_src0[s]       = ins_src0[i];
        disp_src1[s]       = ins_src1[i];
        disp_src_rdy[s][0] = rf_wr[ins_src0[i]];
        disp_src_rdy[s][1] = rf_wr[ins_src1[i]];
        disp_use_imm[s]    = ins_use_imm[i];
        disp_imm[s]        = ins_imm[i];
        disp_dst[s]        = ins_dst[i];
    endtask

    task automatic dispatch_case();
        int p;
        int gap;
        int stall;
        logic [DISP_WIDTH-1:0] acc;
        p = 0;
        gap = 0;
        stall = 0;
        while (p < n_ins) begin
            @(negedge clk);
            disp_vld = '0;
            if (gap > 0) begin
                gap--;
                continue;
            end
            drive_slot(0, p);
            if (p + 1 < n_ins) drive_slot(1, p + 1);
            @(posedge clk);
            acc = disp_accept & disp_vld;
            if (acc == 2'b10) fail_run("slot 1 was accepted without slot 0");
            p += acc[0] + acc[1];
            stall = (acc == '0) ? stall + 1 : 0;
            if (stall > 500) fail_run("dispatch was not accepted in time");
            if (acc == disp_vld) gap = $urandom % 3;
        end
        @(negedge clk);
        disp_vld = '0;
    endtask

    task automatic ext_case();
        int last;
        last = -1;
        for (int e = 0; e < n_ext; e++) begin
            if (ext_cyc[e] > last) last = ext_cyc[e];
        end
        for (int c = 0; c <= last; c++) begin
            @(negedge clk);
            ext_vld = 1'b0;
            for (int e = 0; e < n_ext; e++) begin
                if (ext_cyc[e] == c) begin
                    ext_vld  = 1'b1;
                    ext_tag  = ext_tags[e];
                    ext_data = ext_vals[e];
                end
            end
        end
        @(negedge clk);
        ext_vld = 1'b0;
    endtask

    task automatic run_case();
        word_t cur [PREG_NUM];
        word_t b;
        int    wait_cnt;
        cur = rf_val;
        for (int e = 0; e < n_ext; e++) cur[ext_tags[e]] = ext_vals[e];
        // program-order evaluation gives the expected results
        for (int i = 0; i < n_ins; i++) begin
            b = ins_use_imm[i] ? word_t'($signed(ins_imm[i])) : cur[ins_src1[i]];
            ins_exp[i] = alu_ref(ins_op[i], cur[ins_src0[i]], b);
            cur[ins_dst[i]] = ins_exp[i];
            ins_done[i] = 1'b0;
        end
        pending = n_ins;
        fork
            dispatch_case();
            ext_case();
        join
        wait_cnt = 0;
        while (pending > 0) begin
            @(posedge clk);
            wait_cnt++;
            if (wait_cnt > 2000) fail_run({"writebacks missing at end of case ", case_name});
        end
        $display("case %s done", case_name);
    endtask

    initial begin
        int    fd;
        int    r;
        string tok;
        string line;
        int    f [6];
        void'($urandom(69443));
        rst = 1'b1;
        disp_vld = '0;
        disp_use_imm = '0;
        for (int s = 0; s < DISP_WIDTH; s++) begin
            disp_op[s] = ALU_ADD;
            disp_src0[s] = '0;
            disp_src1[s] = '0;
            disp_src_rdy[s] = '0;
            disp_imm[s] = '0;
            disp_dst[s] = '0;
        end
        for (int l = 0; l < LANE_NUM; l++) begin
            rf_data[l][0] <= '0;
            rf_data[l][1] <= '0;
        end
        ext_vld = 1'b0;
        ext_tag = '0;
        ext_data = '0;
        n_ins = 0;
        n_ext = 0;
        pending = 0;
        case_name = "reset";
        for (int t = 0; t < PREG_NUM; t++) begin
            rf_val[t] = '0;
            rf_wr[t] = 1'b0;
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        // idle cycles after reset with no writeback expected
        repeat (4) @(negedge clk);
        fd = $fopen("int_exec_cases.txt", "r");
        if (fd == 0) fail_run("cannot open the case file");
        while (!$feof(fd)) begin
            r = $fscanf(fd, "%s", tok);
            if (r != 1) break;
            case (tok)
                "#": r = $fgets(line, fd);
                "case": begin
                    r = $fscanf(fd, "%s", case_name);
                    n_ins = 0;
                    n_ext = 0;
                end
                "pre": begin
                    r = $fscanf(fd, "%d %h", f[0], f[1]);
                    rf_val[f[0]] = f[1];
                    rf_wr[f[0]] = 1'b1;
                end
                "ins": begin
                    r = $fscanf(fd, "%d %d %d %d %h %d", f[0], f[1], f[2], f[3], f[4], f[5]);
                    ins_op[n_ins] = f[0];
                    ins_src0[n_ins] = preg_t'(f[1]);
                    ins_src1[n_ins] = preg_t'(f[2]);
                    ins_use_imm[n_ins] = f[3][0];
                    ins_imm[n_ins] = imm_t'(f[4]);
                    ins_dst[n_ins] = preg_t'(f[5]);
                    n_ins++;
                end
                "ext": begin
                    r = $fscanf(fd, "%d %h %d", f[0], f[1], f[2]);
                    ext_tags[n_ext] = preg_t'(f[0]);
                    ext_vals[n_ext] = f[1];
                    ext_cyc[n_ext] = f[2];
                    n_ext++;
                end
                "end": run_case();
                default: fail_run({"unknown keyword in case file: ", tok});
            endcase
        end
        $fclose(fd);
        repeat (4) @(posedge clk);
        if (dut0.u_chk.fail_cnt == 0) begin
            $display("TEST PASSED");
            $finish;
        end else begin
            fail_run("a protocol assertion failed");
        end
    end

endmodule

/* tb_int_exec_assertions.sv */
`timescale 1ns/10ps

module tb_int_exec_assertions (
    input logic                                 clk,
    input logic                                 rst,
    input logic [int_exec_pkg::DISP_WIDTH-1:0]  i_disp_vld,
    input logic [int_exec_pkg::DISP_WIDTH-1:0]  i_disp_accept,
    input logic [int_exec_pkg::LANE_NUM-1:0]    i_wb_vld,
    input int_exec_pkg::preg_t                  i_wb_tag [int_exec_pkg::LANE_NUM]
);
    import int_exec_pkg::*;

    // count of failed assertions
    int fail_cnt = 0;

    // slot 1 never accepted without slot 0
    a_accept_prefix: assert property (@(posedge clk) disable iff (rst)
        i_disp_accept[1] |-> i_disp_accept[0])
        else begin
            $error("slot 1 accepted without slot 0");
            fail_cnt++;
        end

    a_accept_vld: assert property (@(posedge clk) disable iff (rst)
        (i_disp_accept & ~i_disp_vld) == '0)
        else begin
            $error("accept raised on an empty dispatch slot");
            fail_cnt++;
        end

    a_wb_tags: assert property (@(posedge clk) disable iff (rst)
        (&i_wb_vld) |-> (i_wb_tag[0] != i_wb_tag[1]))
        else begin
            $error("both lanes write back the same tag");
            fail_cnt++;
        end

    a_wb_reset: assert property (@(posedge clk) rst |=> (i_wb_vld == '0))
        else begin
            $error("writeback strobe during reset");
            fail_cnt++;
        end

endmodule

bind int_exec_block tb_int_exec_assertions u_chk (
    .clk           (clk),
    .rst           (rst),
    .i_disp_vld    (i_disp_vld),
    .i_disp_accept (o_disp_accept),
    .i_wb_vld      (o_wb_vld),
    .i_wb_tag      (o_wb_tag)
);

/* int_exec_block.sv */
`timescale 1ns/10ps

module int_exec_block #(
    parameter int IQ_DEPTH = 8
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic [int_exec_pkg::DISP_WIDTH-1:0]  i_disp_vld,
    input  int_exec_pkg::alu_op_e                i_disp_op [int_exec_pkg::DISP_WIDTH],
    input  int_exec_pkg::preg_t                  i_disp_src0 [int_exec_pkg::DISP_WIDTH],
    input  int_exec_pkg::preg_t                  i_disp_src1 [int_exec_pkg::DISP_WIDTH],
    input  logic [1:0]                           i_disp_src_rdy [int_exec_pkg::DISP_WIDTH],
    input  logic [int_exec_pkg::DISP_WIDTH-1:0]  i_disp_use_imm,
    input  int_exec_pkg::imm_t                   i_disp_imm [int_exec_pkg::DISP_WIDTH],
    input  int_exec_pkg::preg_t                  i_disp_dst [int_exec_pkg::DISP_WIDTH],
    output logic [int_exec_pkg::DISP_WIDTH-1:0]  o_disp_accept,
    output int_exec_pkg::preg_t                  o_rf_idx [int_exec_pkg::LANE_NUM][2],
    input  int_exec_pkg::word_t                  i_rf_data [int_exec_pkg::LANE_NUM][2],
    output logic [int_exec_pkg::LANE_NUM-1:0]    o_wb_vld,
    output int_exec_pkg::preg_t                  o_wb_tag [int_exec_pkg::LANE_NUM],
    output int_exec_pkg::word_t                  o_wb_data [int_exec_pkg::LANE_NUM],
    input  logic                                 i_ext_wb_vld,
    input  int_exec_pkg::preg_t                  i_ext_wb_tag,
    input  int_exec_pkg::word_t                  i_ext_wb_data
);
    import int_exec_pkg::*;

    // steering to queues
    logic [LANE_NUM-1:0] can_enq;
    logic [LANE_NUM-1:0] enq_vld;
    alu_op_e             enq_op [LANE_NUM];
    preg_t               enq_src0 [LANE_NUM];
    preg_t               enq_src1 [LANE_NUM];
    logic [1:0]          enq_src_rdy [LANE_NUM];
    logic [LANE_NUM-1:0] enq_use_imm;
    imm_t                enq_imm [LANE_NUM];
    preg_t               enq_dst [LANE_NUM];

    // queue to operand stage
    logic [LANE_NUM-1:0] iss_vld;
    alu_op_e             iss_op [LANE_NUM];
    preg_t               iss_src0 [LANE_NUM];
    preg_t               iss_src1 [LANE_NUM];
    logic [LANE_NUM-1:0] iss_use_imm;
    imm_t                iss_imm [LANE_NUM];
    preg_t               iss_dst [LANE_NUM];

    // operand stage to alu
    logic [LANE_NUM-1:0] exe_vld;
    alu_op_e             exe_op [LANE_NUM];
    word_t               exe_a [LANE_NUM];
    word_t               exe_b [LANE_NUM];
    preg_t               exe_dst [LANE_NUM];

    logic [WAKE_NUM-1:0] wake_vld;
    preg_t               wake_tag [WAKE_NUM];

    // lane writebacks, then the external port
    logic [LANE_NUM:0]   byp_vld;
    preg_t               byp_tag [LANE_NUM+1];
    word_t               byp_data [LANE_NUM+1];

    dispatch_steer u_steer (
        .i_disp_vld     (i_disp_vld),
        .i_disp_op      (i_disp_op),
        .i_disp_src0    (i_disp_src0),
        .i_disp_src1    (i_disp_src1),
        .i_disp_src_rdy (i_disp_src_rdy),
        .i_disp_use_imm (i_disp_use_imm),
        .i_disp_imm     (i_disp_imm),
        .i_disp_dst     (i_disp_dst),
        .i_can_enq      (can_enq),
        .o_disp_accept  (o_disp_accept),
        .o_enq_vld      (enq_vld),
        .o_enq_op       (enq_op),
        .o_enq_src0     (enq_src0),
        .o_enq_src1     (enq_src1),
        .o_enq_src_rdy  (enq_src_rdy),
        .o_enq_use_imm  (enq_use_imm),
        .o_enq_imm      (enq_imm),
        .o_enq_dst      (enq_dst)
    );

    for (genvar l = 0; l < LANE_NUM; l++) begin : g_lane
        issue_queue #(
            .IQ_DEPTH (IQ_DEPTH)
        ) u_iq (
            .clk             (clk),
            .rst             (rst),
            .i_enq_vld       (enq_vld[l]),
            .i_enq_op        (enq_op[l]),
            .i_enq_src0      (enq_src0[l]),
            .i_enq_src1      (enq_src1[l]),
            .i_enq_src_rdy   (enq_src_rdy[l]),
            .i_enq_use_imm   (enq_use_imm[l]),
            .i_enq_imm       (enq_imm[l]),
            .i_enq_dst       (enq_dst[l]),
            .i_wake_vld      (wake_vld),
            .i_wake_tag      (wake_tag),
            .o_can_enq       (can_enq[l]),
            .o_issue_vld     (iss_vld[l]),
            .o_issue_op      (iss_op[l]),
            .o_issue_src0    (iss_src0[l]),
            .o_issue_src1    (iss_src1[l]),
            .o_issue_use_imm (iss_use_imm[l]),
            .o_issue_imm     (iss_imm[l]),
            .o_issue_dst     (iss_dst[l])
        );

        assign o_rf_idx[l][0] = iss_src0[l];
        assign o_rf_idx[l][1] = iss_src1[l];

        operand_stage u_opnd (
            .clk             (clk),
            .rst             (rst),
            .i_issue_vld     (iss_vld[l]),
            .i_issue_op      (iss_op[l]),
            .i_issue_src0    (iss_src0[l]),
            .i_issue_src1    (iss_src1[l]),
            .i_issue_use_imm (iss_use_imm[l]),
            .i_issue_imm     (iss_imm[l]),
            .i_issue_dst     (iss_dst[l]),
            .i_rf_data       (i_rf_data[l]),
            .i_byp_vld       (byp_vld),
            .i_byp_tag       (byp_tag),
            .i_byp_data      (byp_data),
            .o_wake_vld      (wake_vld[l]),
            .o_wake_tag      (wake_tag[l]),
            .o_exe_vld       (exe_vld[l]),
            .o_exe_op        (exe_op[l]),
            .o_exe_a         (exe_a[l]),
            .o_exe_b         (exe_b[l]),
            .o_exe_dst       (exe_dst[l])
        );

        alu u_alu (
            .clk       (clk),
            .rst       (rst),
            .i_exe_vld (exe_vld[l]),
            .i_exe_op  (exe_op[l]),
            .i_exe_a   (exe_a[l]),
            .i_exe_b   (exe_b[l]),
            .i_exe_dst (exe_dst[l]),
            .o_wb_vld  (o_wb_vld[l]),
            .o_wb_tag  (o_wb_tag[l]),
            .o_wb_data (o_wb_data[l])
        );

        // writeback slots sit after the announcements
        assign wake_vld[LANE_NUM+l] = o_wb_vld[l];
        assign wake_tag[LANE_NUM+l] = o_wb_tag[l];
        assign byp_vld[l]  = o_wb_vld[l];
        assign byp_tag[l]  = o_wb_tag[l];
        assign byp_data[l] = o_wb_data[l];
    end

    assign wake_vld[WAKE_NUM-1] = i_ext_wb_vld;
    assign wake_tag[WAKE_NUM-1] = i_ext_wb_tag;
    assign byp_vld[LANE_NUM]    = i_ext_wb_vld;
    assign byp_tag[LANE_NUM]    = i_ext_wb_tag;
    assign byp_data[LANE_NUM]   = i_ext_wb_data;

endmodule

/* alu.sv */
`timescale 1ns/10ps

module alu (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  i_exe_vld,
    input  int_exec_pkg::alu_op_e i_exe_op,
    input  int_exec_pkg::word_t   i_exe_a,
    input  int_exec_pkg::word_t   i_exe_b,
    input  int_exec_pkg::preg_t   i_exe_dst,
    output logic                  o_wb_vld,
    output int_exec_pkg::preg_t   o_wb_tag,
    output int_exec_pkg::word_t   o_wb_data
);
    import int_exec_pkg::*;

    word_t                res;
    logic [SHAMT_W-1:0]   shamt;

    assign shamt = i_exe_b[SHAMT_W-1:0];

    always_comb begin
        case (i_exe_op)
            ALU_ADD:  res = i_exe_a + i_exe_b;
            ALU_SUB:  res = i_exe_a - i_exe_b;
            ALU_AND:  res = i_exe_a & i_exe_b;
            ALU_OR:   res = i_exe_a | i_exe_b;
            ALU_XOR:  res = i_exe_a ^ i_exe_b;
            ALU_SLL:  res = i_exe_a << shamt;
            ALU_SRL:  res = i_exe_a >> shamt;
            // compares give 1 or 0
            ALU_SLT:  res = word_t'($signed(i_exe_a) < $signed(i_exe_b));
            ALU_SLTU: res = word_t'(i_exe_a < i_exe_b);
            default:  res = '0;
        endcase
    end

    // one-cycle strobe, no back-pressure
    always_ff @(posedge clk) begin
        if (rst) begin
            o_wb_vld <= 1'b0;
        end else begin
            o_wb_vld <= i_exe_vld;
        end
    end

    always_ff @(posedge clk) begin
        o_wb_tag  <= i_exe_dst;
        o_wb_data <= res;
    end

endmodule

/* operand_stage.sv */
`timescale 1ns/10ps

module operand_stage (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              i_issue_vld,
    input  int_exec_pkg::alu_op_e             i_issue_op,
    input  int_exec_pkg::preg_t               i_issue_src0,
    input  int_exec_pkg::preg_t               i_issue_src1,
    input  logic                              i_issue_use_imm,
    input  int_exec_pkg::imm_t                i_issue_imm,
    input  int_exec_pkg::preg_t               i_issue_dst,
    input  int_exec_pkg::word_t               i_rf_data [2],
    input  logic [int_exec_pkg::LANE_NUM:0]   i_byp_vld,
    input  int_exec_pkg::preg_t               i_byp_tag [int_exec_pkg::LANE_NUM+1],
    input  int_exec_pkg::word_t               i_byp_data [int_exec_pkg::LANE_NUM+1],
    output logic                              o_wake_vld,
    output int_exec_pkg::preg_t               o_wake_tag,
    output logic                              o_exe_vld,
    output int_exec_pkg::alu_op_e             o_exe_op,
    output int_exec_pkg::word_t               o_exe_a,
    output int_exec_pkg::word_t               o_exe_b,
    output int_exec_pkg::preg_t               o_exe_dst
);
    import int_exec_pkg::*;

    logic    s1_vld;
    alu_op_e s1_op;
    preg_t   s1_src0;
    preg_t   s1_src1;
    logic    s1_use_imm;
    imm_t    s1_imm;
    preg_t   s1_dst;

    // a writeback in flight is newer than the register file answer
    function automatic word_t forward(preg_t tag, word_t rf_val);
        word_t val;
        val = rf_val;
        for (int b = 0; b <= LANE_NUM; b++) begin
            if (i_byp_vld[b] && (i_byp_tag[b] == tag)) begin
                val = i_byp_data[b];
            end
        end
        return val;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_vld <= 1'b0;
        end else begin
            s1_vld <= i_issue_vld;
        end
    end

    always_ff @(posedge clk) begin
        s1_op      <= i_issue_op;
        s1_src0    <= i_issue_src0;
        s1_src1    <= i_issue_src1;
        s1_use_imm <= i_issue_use_imm;
        s1_imm     <= i_issue_imm;
        s1_dst     <= i_issue_dst;
    end

    always_comb begin
        o_exe_a = forward(s1_src0, i_rf_data[0]);
        if (s1_use_imm) begin
            o_exe_b = {{(XLEN - IMM_W){s1_imm[IMM_W-1]}}, s1_imm};
        end else begin
            o_exe_b = forward(s1_src1, i_rf_data[1]);
        end
    end

    // result lands on writeback next cycle, so dependents may issue now
    assign o_wake_vld = s1_vld;
    assign o_wake_tag = s1_dst;
    assign o_exe_vld  = s1_vld;
    assign o_exe_op   = s1_op;
    assign o_exe_dst  = s1_dst;

endmodule

/* issue_queue.sv */
`timescale 1ns/10ps

module issue_queue #(
    parameter int IQ_DEPTH = 8
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                i_enq_vld,
    input  int_exec_pkg::alu_op_e               i_enq_op,
    input  int_exec_pkg::preg_t                 i_enq_src0,
    input  int_exec_pkg::preg_t                 i_enq_src1,
    input  logic [1:0]                          i_enq_src_rdy,
    input  logic                                i_enq_use_imm,
    input  int_exec_pkg::imm_t                  i_enq_imm,
    input  int_exec_pkg::preg_t                 i_enq_dst,
    input  logic [int_exec_pkg::WAKE_NUM-1:0]   i_wake_vld,
    input  int_exec_pkg::preg_t                 i_wake_tag [int_exec_pkg::WAKE_NUM],
    output logic                                o_can_enq,
    output logic                                o_issue_vld,
    output int_exec_pkg::alu_op_e               o_issue_op,
    output int_exec_pkg::preg_t                 o_issue_src0,
    output int_exec_pkg::preg_t                 o_issue_src1,
    output logic                                o_issue_use_imm,
    output int_exec_pkg::imm_t                  o_issue_imm,
    output int_exec_pkg::preg_t                 o_issue_dst
);
    import int_exec_pkg::*;

    localparam int IDX_W = $clog2(IQ_DEPTH);

    logic [IQ_DEPTH-1:0] ent_vld;
    alu_op_e             ent_op [IQ_DEPTH];
    preg_t               ent_src0 [IQ_DEPTH];
    preg_t               ent_src1 [IQ_DEPTH];
    logic [1:0]          ent_rdy [IQ_DEPTH];
    logic [IQ_DEPTH-1:0] ent_use_imm;
    imm_t                ent_imm [IQ_DEPTH];
    preg_t               ent_dst [IQ_DEPTH];

    logic [1:0]          rdy_now [IQ_DEPTH];
    logic [IQ_DEPTH-1:0] ent_ready;
    logic [1:0]          enq_rdy;
    logic [IDX_W-1:0]    enq_idx;
    logic [IDX_W-1:0]    iss_idx;
    logic                enq_fire;

    // tag compare against every wake source
    function automatic logic woken(preg_t tag);
        logic hit;
        hit = 1'b0;
        for (int w = 0; w < WAKE_NUM; w++) begin
            hit |= i_wake_vld[w] && (i_wake_tag[w] == tag);
        end
        return hit;
    endfunction

    always_comb begin
        for (int e = 0; e < IQ_DEPTH; e++) begin
            // src1 counts as ready when the immediate replaces it
            rdy_now[e][0] = ent_rdy[e][0] | woken(ent_src0[e]);
            rdy_now[e][1] = ent_rdy[e][1] | ent_use_imm[e] | woken(ent_src1[e]);
            ent_ready[e]  = ent_vld[e] && (&rdy_now[e]);
        end
        enq_rdy[0] = i_enq_src_rdy[0] | woken(i_enq_src0);
        enq_rdy[1] = i_enq_src_rdy[1] | i_enq_use_imm | woken(i_enq_src1);
    end

    // lowest free entry and lowest ready entry
    always_comb begin
        enq_idx = '0;
        iss_idx = '0;
        for (int e = IQ_DEPTH - 1; e >= 0; e--) begin
            if (!ent_vld[e]) begin
                enq_idx = IDX_W'(e);
            end
            if (ent_ready[e]) begin
                iss_idx = IDX_W'(e);
            end
        end
    end

    assign o_can_enq   = ~&ent_vld;
    assign o_issue_vld = |ent_ready;
    assign enq_fire    = i_enq_vld && o_can_enq;

    assign o_issue_op      = ent_op[iss_idx];
    assign o_issue_src0    = ent_src0[iss_idx];
    assign o_issue_src1    = ent_src1[iss_idx];
    assign o_issue_use_imm = ent_use_imm[iss_idx];
    assign o_issue_imm     = ent_imm[iss_idx];
    assign o_issue_dst     = ent_dst[iss_idx];

    always_ff @(posedge clk) begin
        if (rst) begin
            ent_vld <= '0;
        end else begin
            // freed at issue, wakeup is never speculative
            if (o_issue_vld) begin
                ent_vld[iss_idx] <= 1'b0;
            end
            if (enq_fire) begin
                ent_vld[enq_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int e = 0; e < IQ_DEPTH; e++) begin
            ent_rdy[e] <= rdy_now[e];
        end
        if (enq_fire) begin
            ent_op[enq_idx]      <= i_enq_op;
            ent_src0[enq_idx]    <= i_enq_src0;
            ent_src1[enq_idx]    <= i_enq_src1;
            ent_rdy[enq_idx]     <= enq_rdy;
            ent_use_imm[enq_idx] <= i_enq_use_imm;
            ent_imm[enq_idx]     <= i_enq_imm;
            ent_dst[enq_idx]     <= i_enq_dst;
        end
    end

endmodule

/* dispatch_steer.sv */
`timescale 1ns/10ps

module dispatch_steer (
    input  logic [int_exec_pkg::DISP_WIDTH-1:0] i_disp_vld,
    input  int_exec_pkg::alu_op_e               i_disp_op [int_exec_pkg::DISP_WIDTH],
    input  int_exec_pkg::preg_t                 i_disp_src0 [int_exec_pkg::DISP_WIDTH],
    input  int_exec_pkg::preg_t                 i_disp_src1 [int_exec_pkg::DISP_WIDTH],
    input  logic [1:0]                          i_disp_src_rdy [int_exec_pkg::DISP_WIDTH],
    input  logic [int_exec_pkg::DISP_WIDTH-1:0] i_disp_use_imm,
    input  int_exec_pkg::imm_t                  i_disp_imm [int_exec_pkg::DISP_WIDTH],
    input  int_exec_pkg::preg_t                 i_disp_dst [int_exec_pkg::DISP_WIDTH],
    input  logic [int_exec_pkg::LANE_NUM-1:0]   i_can_enq,
    output logic [int_exec_pkg::DISP_WIDTH-1:0] o_disp_accept,
    output logic [int_exec_pkg::LANE_NUM-1:0]   o_enq_vld,
    output int_exec_pkg::alu_op_e               o_enq_op [int_exec_pkg::LANE_NUM],
    output int_exec_pkg::preg_t                 o_enq_src0 [int_exec_pkg::LANE_NUM],
    output int_exec_pkg::preg_t                 o_enq_src1 [int_exec_pkg::LANE_NUM],
    output logic [1:0]                          o_enq_src_rdy [int_exec_pkg::LANE_NUM],
    output logic [int_exec_pkg::LANE_NUM-1:0]   o_enq_use_imm,
    output int_exec_pkg::imm_t                  o_enq_imm [int_exec_pkg::LANE_NUM],
    output int_exec_pkg::preg_t                 o_enq_dst [int_exec_pkg::LANE_NUM]
);
    import int_exec_pkg::*;

    // target queue of each slot
    logic [DISP_WIDTH-1:0] slot_q;

    always_comb begin
        // slot 0 prefers queue 0, slot 1 takes the other one
        slot_q[0] = ~i_can_enq[0];
        slot_q[1] = ~slot_q[0];
        o_disp_accept[0] = i_disp_vld[0] && (|i_can_enq);
        // slot 1 only behind slot 0 keeps acceptance in order
        o_disp_accept[1] = i_disp_vld[1] && o_disp_accept[0] && i_can_enq[slot_q[1]];
    end

    for (genvar q = 0; q < LANE_NUM; q++) begin : g_q
        logic take0;
        logic take1;
        logic sel;

        assign take0 = o_disp_accept[0] && (slot_q[0] == 1'(q));
        assign take1 = o_disp_accept[1] && (slot_q[1] == 1'(q));
        assign sel   = ~take0;

        assign o_enq_vld[q]     = take0 || take1;
        assign o_enq_op[q]      = i_disp_op[sel];
        assign o_enq_src0[q]    = i_disp_src0[sel];
        assign o_enq_src1[q]    = i_disp_src1[sel];
        assign o_enq_src_rdy[q] = i_disp_src_rdy[sel];
        assign o_enq_use_imm[q] = i_disp_use_imm[sel];
        assign o_enq_imm[q]     = i_disp_imm[sel];
        assign o_enq_dst[q]     = i_disp_dst[sel];
    end

endmodule

/* int_exec_pkg.sv */
package int_exec_pkg;

    // datapath width
    localparam int XLEN = 32;
    typedef logic [XLEN-1:0] word_t;

    // physical register tags
    localparam int PREG_NUM = 64;
    typedef logic [$clog2(PREG_NUM)-1:0] preg_t;

    // immediate carried with the instruction, sign-extended at use
    localparam int IMM_W = 12;
    typedef logic [IMM_W-1:0] imm_t;

    // shift amount taken from the low bits of operand b
    localparam int SHAMT_W = $clog2(XLEN);

    // dispatch slots and issue lanes
    localparam int DISP_WIDTH = 2;
    localparam int LANE_NUM = 2;

    // announcement and writeback per lane, plus the external port
    localparam int WAKE_NUM = 2 * LANE_NUM + 1;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SLT  = 4'd7,
        ALU_SLTU = 4'd8
    } alu_op_e;

endpackage
